//--- hdl/arithPkg.sv
// shared types for the accumulator unit
// widths, command opcodes, operand union, command and status words

package arithPkg;

  localparam int ACC_W = 16;  // 4 lookahead slices of 4 bits
  localparam int FAC_W = 8;

  // accumulator commands
  typedef enum logic [1:0] {
    ACC_LOAD = 2'd0,  // acc <= operand word
    ACC_ADD  = 2'd1,  // acc <= acc + word
    ACC_MAC  = 2'd2,  // acc <= acc + facHi * facLo
    ACC_SHR  = 2'd3   // acc <= acc >> word[1:0]
  } accOp_t;

  typedef struct packed {
    logic [FAC_W-1:0] facHi;
    logic [FAC_W-1:0] facLo;
  } facPair_t;

  // one addend, or two factors for a multiply
  typedef union packed {
    logic [ACC_W-1:0] word;
    facPair_t         fac;
  } operand_t;

  typedef struct packed {
    accOp_t   op;
    operand_t arg;
  } accCmd_t;

  typedef struct packed {
    logic [ACC_W-1:0] acc;
    logic             cy;  // carry out, or last bit shifted out
  } accStat_t;

endpackage

//--- hdl/claSlice.sv
// 4-bit lookahead adder slice
// sum bits plus per-bit propagate and generate for the group level

`timescale 1ns/10ps

module claSlice (
  input  logic       cin,
  input  logic [3:0] a,
  input  logic [3:0] b,
  output logic [3:0] sum,
  output logic [3:0] p,
  output logic [3:0] g
);

  logic [3:0] bitCin;  // carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // in-slice lookahead, every carry straight from cin
  assign bitCin[0] = cin;
  assign bitCin[1] = g[0] | (p[0] & cin);
  assign bitCin[2] = g[1]
                   | (p[1] & g[0])
                   | (p[1] & p[0] & cin);
  assign bitCin[3] = g[2]
                   | (p[2] & g[1])
                   | (p[2] & p[1] & g[0])
                   | (p[2] & p[1] & p[0] & cin);

  // slice carry out is left to the group unit
  assign sum = p ^ bitCin;

endmodule

//--- hdl/claGroup.sv
// second-level carry lookahead over four 4-bit groups
// carry[0..2] feed slices 1 to 3, carry[3] is the adder carry out

`timescale 1ns/10ps

module claGroup (
  input  logic                      cin,
  input  logic [arithPkg::ACC_W-1:0] p,
  input  logic [arithPkg::ACC_W-1:0] g,
  output logic [3:0]                carry
);

  logic [3:0] grpP;
  logic [3:0] grpG;

  // reduce each nibble to group propagate / generate
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      grpP[i] = &p[4*i +: 4];
      grpG[i] = g[4*i+3]
              | (p[4*i+3] & g[4*i+2])
              | (p[4*i+3] & p[4*i+2] & g[4*i+1])
              | (p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);
    end
  end

  assign carry[0] = grpG[0] | (grpP[0] & cin);
  assign carry[1] = grpG[1]
                  | (grpP[1] & grpG[0])
                  | (grpP[1] & grpP[0] & cin);
  assign carry[2] = grpG[2]
                  | (grpP[2] & grpG[1])
                  | (grpP[2] & grpP[1] & grpG[0])
                  | (grpP[2] & grpP[1] & grpP[0] & cin);
  assign carry[3] = grpG[3]
                  | (grpP[3] & grpG[2])
                  | (grpP[3] & grpP[2] & grpG[1])
                  | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                  | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cin);

endmodule

//--- hdl/claAdder.sv
// 16-bit two-level carry lookahead adder
// four claSlice instances under one claGroup

`timescale 1ns/10ps

module claAdder (
  input  logic                       C,  // sampling clock for the check only
  input  logic                       cin,
  input  logic [arithPkg::ACC_W-1:0] a,
  input  logic [arithPkg::ACC_W-1:0] b,
  output logic [arithPkg::ACC_W-1:0] sum,
  output logic                       cout
);

  logic [arithPkg::ACC_W-1:0] p;
  logic [arithPkg::ACC_W-1:0] g;
  logic [3:0]                 carry;
  logic [3:0]                 sliceCin;

  assign sliceCin = {carry[2:0], cin};  // slice 0 takes the global carry in

  for (genvar i = 0; i < 4; i++)
  begin : gSlice
    claSlice uSlice (
      .cin (sliceCin[i]),
      .a   (a[4*i +: 4]),
      .b   (b[4*i +: 4]),
      .sum (sum[4*i +: 4]),
      .p   (p[4*i +: 4]),
      .g   (g[4*i +: 4])
    );
  end

  claGroup uGroup (
    .cin   (cin),
    .p     (p),
    .g     (g),
    .carry (carry)
  );

  assign cout = carry[3];

  // lookahead result against a plain 17-bit add
  aSumOk : assert property (@(posedge C)
    !$isunknown({a, b, cin}) |->
      {cout, sum} == ({1'b0, a} + {1'b0, b} + {{arithPkg::ACC_W{1'b0}}, cin}))
    else $error("lookahead sum differs from a + b + cin");

endmodule

//--- hdl/arrayMult.sv
// unsigned 8x8 array multiplier
// masked shifted partial products summed in a balanced tree

`timescale 1ns/10ps

module arrayMult (
  input  logic [arithPkg::FAC_W-1:0] a,
  input  logic [arithPkg::FAC_W-1:0] b,
  output logic [arithPkg::ACC_W-1:0] prod
);

  logic [arithPkg::ACC_W-1:0] pp [arithPkg::FAC_W];
  logic [arithPkg::ACC_W-1:0] lvl1 [4];
  logic [arithPkg::ACC_W-1:0] lvl2 [2];

  // one row per multiplier bit, a shifted and gated by b[i]
  always_comb
  begin
    for (int i = 0; i < arithPkg::FAC_W; i++)
    begin
      pp[i] = ({{(arithPkg::ACC_W-arithPkg::FAC_W){1'b0}}, a} << i)
            & {arithPkg::ACC_W{b[i]}};
    end
  end

  // pairwise adds, three levels deep
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      lvl1[i] = pp[2*i] + pp[2*i+1];
    end
    for (int i = 0; i < 2; i++)
    begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
  end

  assign prod = lvl2[0] + lvl2[1];  // max 0xFE01, never wraps

endmodule

//--- hdl/accumCore.sv
// accumulator register with asynchronous clear
// command decode, adder operand select, right shifter, carry/round flag

`timescale 1ns/10ps

module accumCore (
  input  logic                       C,
  input  logic                       CLR,
  input  logic                       en,
  input  arithPkg::accCmd_t          cmd,
  input  logic [arithPkg::ACC_W-1:0] sum,
  input  logic                       cout,
  input  logic [arithPkg::ACC_W-1:0] prod,
  output logic [arithPkg::ACC_W-1:0] addA,
  output logic [arithPkg::ACC_W-1:0] addB,
  output arithPkg::accStat_t         stat
);

  logic [arithPkg::ACC_W-1:0] acc;
  logic                       cy;
  logic [1:0]                 shAmt;
  logic [arithPkg::ACC_W-1:0] shVal;
  logic                       shCy;

  // adder operands
  assign addA = acc;
  assign addB = (cmd.op == arithPkg::ACC_MAC) ? prod : cmd.arg.word;

  assign shAmt = cmd.arg.word[1:0];
  assign shVal = acc >> shAmt;

  // last bit pushed out the bottom
  always_comb
  begin
    case (shAmt)
      2'd1:    shCy = acc[0];
      2'd2:    shCy = acc[1];
      2'd3:    shCy = acc[2];
      default: shCy = 1'b0;  // no shift, nothing lost
    endcase
  end

  always_ff @(posedge C or posedge CLR)
  begin
    if (CLR)
    begin
      acc <= '0;
      cy  <= 1'b0;
    end
    else if (en)
    begin
      case (cmd.op)
        arithPkg::ACC_LOAD:
        begin
          acc <= cmd.arg.word;
          cy  <= 1'b0;
        end
        arithPkg::ACC_ADD,
        arithPkg::ACC_MAC:
        begin
          acc <= sum;
          cy  <= cout;
        end
        arithPkg::ACC_SHR:
        begin
          acc <= shVal;
          cy  <= shCy;
        end
        default:
        begin
          acc <= acc;
          cy  <= cy;
        end
      endcase
    end
  end

  assign stat.acc = acc;
  assign stat.cy  = cy;

  // a strobed command must carry a real opcode
  aOpKnown : assert property (@(posedge C) disable iff (CLR)
    en |-> !$isunknown(cmd.op))
    else $error("unknown opcode with en high");

  // load always leaves the flag clear
  aLoadCy : assert property (@(posedge C) disable iff (CLR)
    (en && cmd.op == arithPkg::ACC_LOAD) |=> !stat.cy)
    else $error("cy set after load");

endmodule

//--- hdl/arithUnit.sv
// accumulator unit top level
// multiplier and lookahead adder around the accumulator core

`timescale 1ns/10ps

module arithUnit (
  input  logic               C,
  input  logic               CLR,
  input  logic               en,
  input  arithPkg::accCmd_t  cmd,
  output arithPkg::accStat_t stat
);

  logic [arithPkg::ACC_W-1:0] prod;
  logic [arithPkg::ACC_W-1:0] addA;
  logic [arithPkg::ACC_W-1:0] addB;
  logic [arithPkg::ACC_W-1:0] sum;
  logic                       cout;

  // operand bytes as the two factors
  arrayMult uMult (
    .a    (cmd.arg.fac.facHi),
    .b    (cmd.arg.fac.facLo),
    .prod (prod)
  );

  claAdder uAdder (
    .C    (C),
    .cin  (1'b0),  // accumulate only, no carry chaining
    .a    (addA),
    .b    (addB),
    .sum  (sum),
    .cout (cout)
  );

  accumCore uCore (
    .C    (C),
    .CLR  (CLR),
    .en   (en),
    .cmd  (cmd),
    .sum  (sum),
    .cout (cout),
    .prod (prod),
    .addA (addA),
    .addB (addB),
    .stat (stat)
  );

endmodule

//--- test/arithModel.svh
// reference model for the accumulator unit
// accRef computes the next expected status, checkVal compares one value

// next expected state from the previous one and a strobed command
function automatic arithPkg::accStat_t accRef(
  input arithPkg::accStat_t prev,
  input arithPkg::accCmd_t  c
);
  arithPkg::accStat_t         nxt;
  logic [arithPkg::ACC_W:0]   wide;     // sum with its carry bit
  logic [arithPkg::ACC_W-1:0] product;
  int                         n;

  nxt = prev;
  case (c.op)
    arithPkg::ACC_LOAD:
    begin
      nxt.acc = c.arg.word;
      nxt.cy  = 1'b0;
    end
    arithPkg::ACC_ADD:
    begin
      wide    = {1'b0, prev.acc} + {1'b0, c.arg.word};
      nxt.acc = wide[arithPkg::ACC_W-1:0];
      nxt.cy  = wide[arithPkg::ACC_W];
    end
    arithPkg::ACC_MAC:
    begin
      product = c.arg.fac.facHi * c.arg.fac.facLo;  // unsigned, fits 16 bits
      wide    = {1'b0, prev.acc} + {1'b0, product};
      nxt.acc = wide[arithPkg::ACC_W-1:0];
      nxt.cy  = wide[arithPkg::ACC_W];
    end
    default:
    begin
      // logical right shift, cy keeps the last bit dropped
      n       = c.arg.word[1:0];
      nxt.acc = prev.acc >> n;
      if (n == 0)
      begin
        nxt.cy = 1'b0;
      end
      else
      begin
        nxt.cy = prev.acc[n-1];
      end
    end
  endcase
  return nxt;
endfunction

// one compare, stops the run on the first difference
task automatic checkVal(
  input logic [arithPkg::ACC_W-1:0] got,
  input logic [arithPkg::ACC_W-1:0] exp,
  input string                      what
);
  if (got !== exp)
  begin
    $display("MISMATCH at %0.1f ns: %s, got 0x%h expected 0x%h",
             $realtime, what, got, exp);
    $display("sim failed");
    $fatal(1, "stopping at the first mismatch");
  end
endtask

//--- test/arithTb.sv
// testbench for the accumulator unit
// clock, reset, directed and random commands, checker and watchdog

`timescale 1ns/10ps

module arithTb;

  localparam int N_DIRECTED = 32;    // directed command slots
  localparam int N_RAND     = 2000;
  localparam int N_CMD      = N_DIRECTED + N_RAND;
  localparam int WATCH_NS   = (N_CMD + 20) * 4;

  logic               C     = 1'b0;
  logic               CLR   = 1'b1;
  logic               en    = 1'b0;
  arithPkg::accCmd_t  cmd   = '0;
  arithPkg::accStat_t stat;
  arithPkg::accStat_t expSt = '0;  // model state
  integer             seed  = 61378;
  logic [31:0]        r;

  `include "arithModel.svh"

  arithUnit dut (
    .C    (C),
    .CLR  (CLR),
    .en   (en),
    .cmd  (cmd),
    .stat (stat)
  );

  always #2 C = ~C;  // 4 ns period

  // one command slot, driven just after the rising edge
  task automatic sendCmd(
    input arithPkg::accOp_t op,
    input logic [15:0]      word,
    input logic             enVal
  );
    @(posedge C);
    #1;
    en           = enVal;
    cmd.op       = op;
    cmd.arg.word = word;
  endtask

  // CLR between edges must clear stat with no clock
  task automatic clearMidStream();
    @(posedge C);
    #1;
    CLR = 1'b1;
    en  = 1'b0;
    #0.5;
    checkVal(stat.acc, '0, "acc not cleared by CLR before a clock edge");
    checkVal(stat.cy, 1'b0, "cy not cleared by CLR before a clock edge");
    @(posedge C);
    #1;
    CLR = 1'b0;
  endtask

  // model update at the edge, compare once stat has settled
  initial
  begin : stateCompare
    forever
    begin
      @(posedge C);
      if (CLR)
        expSt = '0;
      else if (en)
        expSt = accRef(expSt, cmd);
      @(negedge C);
      if (CLR)
        expSt = '0;  // async clear, no edge needed
      checkVal(stat.acc, expSt.acc, "acc");
      checkVal(stat.cy, expSt.cy, "cy");
    end
  end

  initial
  begin : stimulus
    repeat (3) @(posedge C);
    #1;
    CLR = 1'b0;
    checkVal(stat.acc, '0, "acc after reset");
    checkVal(stat.cy, 1'b0, "cy after reset");

    sendCmd(arithPkg::ACC_LOAD, 16'h1234, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h0001, 1'b1);

    // carries across each nibble boundary
    sendCmd(arithPkg::ACC_LOAD, 16'h000F, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h0001, 1'b1);
    sendCmd(arithPkg::ACC_LOAD, 16'h00FF, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h0001, 1'b1);
    sendCmd(arithPkg::ACC_LOAD, 16'h0FFF, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h0001, 1'b1);
    sendCmd(arithPkg::ACC_LOAD, 16'hFFFF, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h0001, 1'b1);   // wraps to 0, cy 1
    sendCmd(arithPkg::ACC_ADD, 16'hFFFF, 1'b1);
    sendCmd(arithPkg::ACC_ADD, 16'h8001, 1'b1);

    // multiply-accumulate, hi byte times lo byte
    sendCmd(arithPkg::ACC_LOAD, 16'h0000, 1'b1);
    sendCmd(arithPkg::ACC_MAC, 16'hFFFF, 1'b1);   // 0xFE01
    sendCmd(arithPkg::ACC_MAC, 16'hFFFF, 1'b1);   // overflows, cy 1
    sendCmd(arithPkg::ACC_MAC, 16'h1234, 1'b1);
    sendCmd(arithPkg::ACC_MAC, 16'h00AB, 1'b1);   // zero factor

    // right shifts 0..3
    sendCmd(arithPkg::ACC_LOAD, 16'hB6D5, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0000, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0001, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0002, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0003, 1'b1);
    sendCmd(arithPkg::ACC_LOAD, 16'h0006, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0003, 1'b1);   // bit 2 out, cy 1
    sendCmd(arithPkg::ACC_LOAD, 16'h0001, 1'b1);
    sendCmd(arithPkg::ACC_SHR, 16'h0001, 1'b1);

    // en low, stat must hold
    sendCmd(arithPkg::ACC_ADD, 16'h7777, 1'b0);
    sendCmd(arithPkg::ACC_LOAD, 16'h0000, 1'b0);

    for (int i = 0; i < N_RAND; i++)
    begin
      if (i == N_RAND / 2)
      begin
        sendCmd(arithPkg::ACC_LOAD, 16'hA5A5, 1'b1);  // nonzero before the clear
        clearMidStream();
      end
      r = $random(seed);
      sendCmd(arithPkg::accOp_t'(r[1:0]), r[17:2], r[18] | r[19]);  // en high 3 of 4
    end

    sendCmd(arithPkg::ACC_LOAD, 16'h0000, 1'b0);
    repeat (2) @(negedge C);  // last compare done
    #1;
    $display("sim passed");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCH_NS);
    $display("timeout: the command stream did not finish in the expected time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- arith.f
+incdir+test
hdl/arithPkg.sv
hdl/claSlice.sv
hdl/claGroup.sv
hdl/claAdder.sv
hdl/arrayMult.sv
hdl/accumCore.sv
hdl/arithUnit.sv
test/arithTb.sv
